/* ppu_top.f */
+incdir+.
ppu_ctrl_pkg.sv
ppu_data_pkg.sv
word_sram.sv
ppu.sv
ppu_ctrl.sv
ppu_top.sv
ppu_checker.sv
tb_ppu_top.sv

/* tb_ppu_top.sv */
/*
 * tb_ppu_top
 * seeded random tiles through the writeback stage, readback of the results,
 * cycle limit and closing summary
 */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module tb_ppu_top;

    import ppu_ctrl_pkg::*;
    import ppu_data_pkg::*;

    localparam int NUM_TESTS = 12;
    localparam int OVERHEAD  = 140;  // psum load, readback slack, chained readback

    logic      clk;
    logic      rst;
    logic      psum_we;
    addr_t     psum_addr;
    word_t     psum_wdata;
    logic      start;
    addr_t     src_base;
    addr_t     dst_base;
    len_t      tile_len;
    shift_t    shift;
    ppu_op_t   op;
    lane_sel_t lanes;
    logic      busy;
    logic      done;
    logic      out_rd_en;
    addr_t     out_rd_addr;
    word_t     out_rd_data;
    int        chk_errors;
    int        chk_checks;

    // test table
    string     t_name    [NUM_TESTS];
    addr_t     t_src     [NUM_TESTS];
    addr_t     t_dst     [NUM_TESTS];
    len_t      t_len     [NUM_TESTS];
    shift_t    t_shift   [NUM_TESTS];
    ppu_op_t   t_op      [NUM_TESTS];
    lane_sel_t t_lanes   [NUM_TESTS];
    bit        t_restart [NUM_TESTS];  // second start while busy
    bit        t_b2b     [NUM_TESTS];  // follows the previous tile directly

    int tb_errors;
    int cycles;
    int limit;
    int errs_before;

    ppu_top dut (.*);

    ppu_checker chk (
        .clk(clk), .rst(rst), .psum_we(psum_we), .psum_addr(psum_addr),
        .psum_wdata(psum_wdata), .start(start), .src_base(src_base),
        .dst_base(dst_base), .tile_len(tile_len), .shift(shift), .op(op),
        .lanes(lanes), .busy(busy), .done(done), .out_rd_en(out_rd_en),
        .out_rd_addr(out_rd_addr), .out_rd_data(out_rd_data),
        .errors(chk_errors), .checks(chk_checks)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run passed its limit of %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    // inputs change 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // mostly random, some saturating corner values
    function automatic logic [15:0] rand_lane();
        case ($urandom % 8)
            0: return 16'h7fff;
            1: return 16'h8000;
            2: return 16'hffff;
            3: return 16'h0000;
            default: return 16'($urandom);
        endcase
    endfunction

    task automatic set_test(input int i, input string name, input int src, input int dst,
                            input int len, input ppu_op_t o, input logic [3:0] ln);
        t_name[i]    = name;
        t_src[i]     = addr_t'(src);
        t_dst[i]     = addr_t'(dst);
        t_len[i]     = len_t'(len);
        t_shift[i]   = shift_t'($urandom % 16);
        t_op[i]      = o;
        t_lanes[i]   = lane_sel_t'(ln);
        t_restart[i] = 1'b0;
        t_b2b[i]     = 1'b0;
    endtask

    task automatic build_tests();
        ppu_op_t rq;
        rq = ($urandom % 2) ? OP_REQUANT_RELU : OP_REQUANT;
        set_test(0, "bypass_full", 0, 0, 64, OP_BYPASS, 4'b0000);
        set_test(1, "bypass", $urandom, $urandom, 1 + $urandom % 64, OP_BYPASS, 4'b0101);
        set_test(2, "requant", $urandom, $urandom, 1 + $urandom % 64, OP_REQUANT, 4'b1111);
        t_shift[2] = shift_t'($urandom % 4);  // small shift, corner psums hit both clamps
        set_test(3, "requant", $urandom, $urandom, 1 + $urandom % 64, OP_REQUANT, 4'b1111);
        set_test(4, "requant_relu", $urandom, $urandom, 1 + $urandom % 64,
                 OP_REQUANT_RELU, 4'b1111);
        set_test(5, "lane_lower", $urandom, $urandom, 1 + $urandom % 64, rq, 4'b0011);
        set_test(6, "lane_upper", $urandom, $urandom, 1 + $urandom % 64, rq, 4'b1100);
        set_test(7, "lane_none", $urandom, $urandom, 1 + $urandom % 64, OP_REQUANT, 4'b0000);
        set_test(8, "lane_invalid", $urandom, $urandom, 1 + $urandom % 64,
                 OP_REQUANT_RELU, 4'b1001);
        set_test(9, "restart_busy", $urandom, $urandom, 16 + $urandom % 48, OP_REQUANT, 4'b1111);
        t_restart[9] = 1'b1;
        set_test(10, "full_bank", 33, 63, 64, OP_REQUANT, 4'b1111);
        set_test(11, "b2b_wrap", 58, 55, 20, OP_REQUANT_RELU, 4'b1111);
        t_b2b[11] = 1'b1;  // short tile over part of the full one
    endtask

    task automatic load_psums();
        for (int k = 0; k < `PPU_DEPTH; k++) begin
            tick();
            psum_we    = 1'b1;
            psum_addr  = addr_t'(k);
            psum_wdata = {rand_lane(), rand_lane()};
        end
        tick();
        psum_we = 1'b0;
    endtask

    // start strobe, optional stray start, then wait for done
    task automatic run_tile(input int i);
        int n;
        start    = 1'b1;
        src_base = t_src[i];
        dst_base = t_dst[i];
        tile_len = t_len[i];
        shift    = t_shift[i];
        op       = t_op[i];
        lanes    = t_lanes[i];
        tick();
        start = 1'b0;
        if (t_restart[i]) begin
            repeat (3) tick();
            start    = 1'b1;  // must be ignored
            dst_base = t_dst[i] + addr_t'(7);
            tile_len = len_t'(5);
            op       = OP_BYPASS;
            tick();
            start = 1'b0;
        end
        n = 0;
        while (!done && n < int'(t_len[i]) + 8) begin
            tick();
            n++;
        end
        if (!done) begin
            $display("test %0d: done never arrived", i);
            tb_errors++;
        end
        tick();  // first idle cycle
    endtask

    task automatic read_back(input addr_t base, input len_t len);
        for (int k = 0; k < int'(len); k++) begin
            out_rd_en   = 1'b1;
            out_rd_addr = base + addr_t'(k);
            tick();
        end
        out_rd_en = 1'b0;
        repeat (2) tick();  // last compare
    endtask

    initial begin
        rst = 1'b1;
        psum_we = 1'b0;
        psum_addr = '0;
        psum_wdata = '0;
        start = 1'b0;
        src_base = '0;
        dst_base = '0;
        tile_len = '0;
        shift = '0;
        op = OP_BYPASS;
        lanes = LANE_NONE;
        out_rd_en = 1'b0;
        out_rd_addr = '0;
        tb_errors = 0;
        cycles = 0;
        limit = 0;
        void'($urandom(32'h85f3_00ef));
        build_tests();
        limit = 16;
        for (int i = 0; i < NUM_TESTS; i++) begin
            limit += 2 * int'(t_len[i]) + 3 + OVERHEAD;
        end
        limit *= 2;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            errs_before = chk_errors + tb_errors;
            if (!t_b2b[i]) begin
                load_psums();
            end
            run_tile(i);
            if (!(i + 1 < NUM_TESTS && t_b2b[i + 1])) begin
                read_back(t_dst[i], t_len[i]);
                if (t_b2b[i]) begin
                    read_back(t_dst[i - 1], t_len[i - 1]);  // earlier tile of the pair
                end
            end
            $display("test %0d %s len %0d shift %0d: %s", i, t_name[i], t_len[i], t_shift[i],
                     (chk_errors + tb_errors == errs_before) ? "ok" : "mismatch");
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, chk_checks,
                 chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* ppu_checker.sv */
/*
 * ppu_checker
 * watches the DUT ports, mirrors the psum bank, models the output bank
 * and compares readback data and done timing against it
 */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module ppu_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psum_we,
    input  ppu_ctrl_pkg::addr_t     psum_addr,
    input  ppu_data_pkg::word_t     psum_wdata,
    input  logic                    start,
    input  ppu_ctrl_pkg::addr_t     src_base,
    input  ppu_ctrl_pkg::addr_t     dst_base,
    input  ppu_ctrl_pkg::len_t      tile_len,
    input  ppu_ctrl_pkg::shift_t    shift,
    input  ppu_ctrl_pkg::ppu_op_t   op,
    input  ppu_data_pkg::lane_sel_t lanes,
    input  logic                    busy,
    input  logic                    done,
    input  logic                    out_rd_en,
    input  ppu_ctrl_pkg::addr_t     out_rd_addr,
    input  ppu_data_pkg::word_t     out_rd_data,
    output int                      errors,
    output int                      checks
);

    import ppu_ctrl_pkg::*;
    import ppu_data_pkg::*;

    word_t psum_m [`PPU_DEPTH];  // copy of the psum bank
    word_t exp_m  [`PPU_DEPTH];  // expected output bank, x until written
    logic  active;               // tile in flight
    int    lat;                  // cycles since the start cycle
    int    exp_lat;
    logic  rd_pend;
    addr_t rd_addr_q;

    // shift, optional relu, add zero point, clamp to 0..255
    function automatic byte_t quantize_lane(input logic [15:0] v, input int sh, input bit relu);
        int t;
        t = int'($signed(v));
        t = t >>> sh;
        if (relu && t < 0) begin
            t = 0;
        end
        t = t + `PPU_ZERO_POINT;
        if (t > `PPU_QMAX) begin
            t = `PPU_QMAX;
        end
        if (t < 0) begin
            t = 0;
        end
        return t[7:0];
    endfunction

    // fold a whole accepted tile into the expected bank
    task automatic apply_tile();
        word_t      src_w;
        word_t      new_w;
        logic [3:0] be;
        addr_t      da;
        bit         relu;
        relu = (op == OP_REQUANT_RELU);
        if (op == OP_BYPASS) begin
            be = 4'b1111;  // bypass writes every byte
        end else if (lanes == 4'b0011 || lanes == 4'b1100 || lanes == 4'b1111) begin
            be = lanes;
        end else begin
            be = 4'b0000;  // unknown select writes nothing
        end
        for (int k = 0; k < int'(tile_len); k++) begin
            src_w = psum_m[src_base + addr_t'(k)];  // wraps at bank end
            da    = dst_base + addr_t'(k);
            if (op == OP_BYPASS) begin
                new_w = src_w;
            end else begin
                new_w = {8'd0, quantize_lane(src_w[31:16], int'(shift), relu),
                         8'd0, quantize_lane(src_w[15:0], int'(shift), relu)};
            end
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    exp_m[da][b*8 +: 8] = new_w[b*8 +: 8];
                end
            end
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            active  = 1'b0;
            rd_pend = 1'b0;
        end else begin
            if (psum_we) begin
                psum_m[psum_addr] = psum_wdata;
            end
            // readback data is due one cycle after the read
            if (rd_pend) begin
                checks++;
                if (out_rd_data !== exp_m[rd_addr_q]) begin
                    $display("[ERROR] out_rd_data @%h: got %h, expected %h",
                             rd_addr_q, out_rd_data, exp_m[rd_addr_q]);
                    errors++;
                end
            end
            rd_pend   = out_rd_en;
            rd_addr_q = out_rd_addr;
            // tile timing, lat is the cycle index being sampled
            if (active) begin
                lat++;
                if (!busy) begin
                    $display("[ERROR] busy %0d cycles after start: got %h, expected %h",
                             lat, busy, 1'b1);
                    errors++;
                end
                if (done) begin
                    checks++;
                    if (lat != exp_lat) begin
                        $display("[ERROR] done latency: got %h, expected %h", lat, exp_lat);
                        errors++;
                    end
                    active = 1'b0;
                end else if (lat >= exp_lat) begin
                    $display("done did not pulse within %0d cycles of start", exp_lat);
                    errors++;
                    active = 1'b0;
                end
            end else if (done) begin
                $display("[ERROR] done with no tile running: got %h, expected %h", done, 1'b0);
                errors++;
            end
            // start only counts while idle
            if (start && !busy) begin
                apply_tile();
                active  = 1'b1;
                lat     = 0;
                exp_lat = int'(tile_len) + 3;
            end
        end
    end

endmodule

/* ppu_top.sv */
/*
 * ppu_top
 * writeback stage: psum bank, tile controller, PPU and output bank
 */
`timescale 1ns/1ps

module ppu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psum_we,
    input  ppu_ctrl_pkg::addr_t     psum_addr,
    input  ppu_data_pkg::word_t     psum_wdata,
    input  logic                    start,
    input  ppu_ctrl_pkg::addr_t     src_base,
    input  ppu_ctrl_pkg::addr_t     dst_base,
    input  ppu_ctrl_pkg::len_t      tile_len,
    input  ppu_ctrl_pkg::shift_t    shift,
    input  ppu_ctrl_pkg::ppu_op_t   op,
    input  ppu_data_pkg::lane_sel_t lanes,
    output logic                    busy,
    output logic                    done,
    input  logic                    out_rd_en,
    input  ppu_ctrl_pkg::addr_t     out_rd_addr,
    output ppu_data_pkg::word_t     out_rd_data
);

    import ppu_ctrl_pkg::*;
    import ppu_data_pkg::*;

    logic      psum_rd_en;
    addr_t     psum_rd_addr;
    word_t     psum_rdata;
    logic      ppu_valid;
    shift_t    ppu_shift;
    ppu_op_t   ppu_op;
    lane_sel_t ppu_lanes;
    logic      ppu_out_valid;
    word_t     ppu_wdata;
    logic      wr_en;
    logic [3:0] wr_be;
    addr_t     wr_addr;

    // host loads whole words
    word_sram psum_bank (
        .clk   (clk),
        .we    (psum_we),
        .be    (4'b1111),
        .waddr (psum_addr),
        .wdata (psum_wdata),
        .re    (psum_rd_en),
        .raddr (psum_rd_addr),
        .rdata (psum_rdata)
    );

    ppu_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .src_base      (src_base),
        .dst_base      (dst_base),
        .tile_len      (tile_len),
        .shift_in      (shift),
        .op_in         (op),
        .lanes_in      (lanes),
        .rd_en         (psum_rd_en),
        .rd_addr       (psum_rd_addr),
        .ppu_valid     (ppu_valid),
        .shift         (ppu_shift),
        .op            (ppu_op),
        .lanes         (ppu_lanes),
        .ppu_out_valid (ppu_out_valid),
        .wr_en         (wr_en),
        .wr_be         (wr_be),
        .wr_addr       (wr_addr),
        .busy          (busy),
        .done          (done)
    );

    ppu u_ppu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ppu_valid),
        .data_in   (psum_rdata),
        .shift     (ppu_shift),
        .op        (ppu_op),
        .lanes     (ppu_lanes),
        .out_valid (ppu_out_valid),
        .data_out  (ppu_wdata)
    );

    // written by the PPU, read back by the host
    word_sram out_bank (
        .clk   (clk),
        .we    (wr_en),
        .be    (wr_be),
        .waddr (wr_addr),
        .wdata (ppu_wdata),
        .re    (out_rd_en),
        .raddr (out_rd_addr),
        .rdata (out_rd_data)
    );

endmodule

/* ppu_ctrl.sv */
/*
 * ppu_ctrl
 * tile sequencer: latches the command, streams psum reads,
 * issues masked output writes and pulses done after the last one
 */
`timescale 1ns/1ps

module ppu_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  ppu_ctrl_pkg::addr_t     src_base,
    input  ppu_ctrl_pkg::addr_t     dst_base,
    input  ppu_ctrl_pkg::len_t      tile_len,
    input  ppu_ctrl_pkg::shift_t    shift_in,
    input  ppu_ctrl_pkg::ppu_op_t   op_in,
    input  ppu_data_pkg::lane_sel_t lanes_in,
    output logic                    rd_en,
    output ppu_ctrl_pkg::addr_t     rd_addr,
    output logic                    ppu_valid,
    output ppu_ctrl_pkg::shift_t    shift,
    output ppu_ctrl_pkg::ppu_op_t   op,
    output ppu_data_pkg::lane_sel_t lanes,
    input  logic                    ppu_out_valid,
    output logic                    wr_en,
    output logic [3:0]              wr_be,
    output ppu_ctrl_pkg::addr_t     wr_addr,
    output logic                    busy,
    output logic                    done
);

    import ppu_ctrl_pkg::*;
    import ppu_data_pkg::*;

    tile_state_t state;
    addr_t       src_q;
    addr_t       dst_q;
    len_t        len_q;
    len_t        rd_cnt;   // reads issued
    len_t        wr_cnt;   // writes landed
    logic        last_rd;

    assign last_rd = (rd_cnt == len_q - len_t'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            rd_cnt    <= '0;
            wr_cnt    <= '0;
            ppu_valid <= 1'b0;
        end else begin
            ppu_valid <= rd_en;  // matches the sram read latency
            if (wr_en) begin
                wr_cnt <= wr_cnt + len_t'(1);
            end
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state  <= ST_READ;
                        rd_cnt <= '0;
                        wr_cnt <= '0;
                    end
                end
                ST_READ: begin
                    rd_cnt <= rd_cnt + len_t'(1);
                    if (last_rd) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // tile fields, held for the whole tile
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            src_q <= src_base;
            dst_q <= dst_base;
            len_q <= tile_len;
            shift <= shift_in;
            op    <= op_in;
            lanes <= lanes_in;
        end
    end

    assign rd_en   = (state == ST_READ);
    assign rd_addr = src_q + addr_t'(rd_cnt);  // wraps mod depth
    assign wr_en   = ppu_out_valid;
    assign wr_addr = dst_q + addr_t'(wr_cnt);
    assign busy    = (state != ST_IDLE);
    assign done    = (state == ST_DRAIN) && (wr_cnt == len_q);

    // byte enables, unknown patterns write nothing
    always_comb begin
        if (op == OP_BYPASS) begin
            wr_be = 4'b1111;
        end else begin
            case (lanes)
                LANE_LOWER, LANE_UPPER, LANE_BOTH: wr_be = lanes;
                default:                           wr_be = 4'b0000;
            endcase
        end
    end

endmodule

/* ppu.sv */
/*
 * ppu
 * two lane requantize, optional ReLU, zero point and clamp to uint8
 * bypass passes the raw word, one output register stage
 */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module ppu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  ppu_data_pkg::word_t     data_in,
    input  ppu_ctrl_pkg::shift_t    shift,
    input  ppu_ctrl_pkg::ppu_op_t   op,
    input  ppu_data_pkg::lane_sel_t lanes,
    output logic                    out_valid,
    output ppu_data_pkg::word_t     data_out
);

    import ppu_ctrl_pkg::*;
    import ppu_data_pkg::*;

    lane_t lane_down;
    lane_t lane_up;
    byte_t q_down;
    byte_t q_up;
    logic  relu_en;
    word_t packed_q;

    // shift, relu, +zp, clamp for one lane
    function automatic byte_t requant_lane(
        input lane_t  v,
        input shift_t sh,
        input logic   relu
    );
        lane_t                          shifted;
        logic signed [`PPU_LANE_BITS+1:0] acc;  // two guard bits for +zp
        shifted = v >>> sh;
        if (relu && shifted < 0) begin
            shifted = '0;
        end
        acc = {{2{shifted[`PPU_LANE_BITS-1]}}, shifted} + (`PPU_LANE_BITS+2)'(`PPU_ZERO_POINT);
        if (acc >= `PPU_QMAX) begin
            return byte_t'(`PPU_QMAX);  // saturate high
        end else if (acc <= 0) begin
            return '0;
        end
        return acc[7:0];
    endfunction

    assign relu_en = (op == OP_REQUANT_RELU);

    // lane masking from the select pattern
    always_comb begin
        case (lanes)
            LANE_BOTH: begin
                lane_down = data_in[15:0];
                lane_up   = data_in[31:16];
            end
            LANE_LOWER: begin
                lane_down = data_in[15:0];
                lane_up   = '0;
            end
            LANE_UPPER: begin
                lane_down = '0;
                lane_up   = data_in[31:16];
            end
            default: begin  // none or unknown pattern
                lane_down = '0;
                lane_up   = '0;
            end
        endcase
    end

    assign q_down   = requant_lane(lane_down, shift, relu_en);
    assign q_up     = requant_lane(lane_up, shift, relu_en);
    assign packed_q = {8'd0, q_up, 8'd0, q_down};  // uint8 in bytes 0 and 2

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload reg, no reset
    always_ff @(posedge clk) begin
        if (in_valid) begin
            data_out <= (op == OP_BYPASS) ? data_in : packed_q;
        end
    end

endmodule

/* word_sram.sv */
/*
 * word_sram
 * single clock word memory with byte write enables and a registered read
 */
`timescale 1ns/1ps
`include "ppu_defines.svh"

module word_sram (
    input  logic                 clk,
    input  logic                 we,
    input  logic [3:0]           be,
    input  ppu_ctrl_pkg::addr_t  waddr,
    input  ppu_data_pkg::word_t  wdata,
    input  logic                 re,
    input  ppu_ctrl_pkg::addr_t  raddr,
    output ppu_data_pkg::word_t  rdata
);

    import ppu_data_pkg::*;

    word_t mem [`PPU_DEPTH];  // no reset on the array

    // byte lane writes
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // read data lands next cycle
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end  // holds otherwise
    end

endmodule

/* ppu_data_pkg.sv */
/*
 * PPU datapath types
 * packed word, lane and byte types plus the lane select patterns
 */
package ppu_data_pkg;

    `include "ppu_defines.svh"

    typedef logic [`PPU_DATA_BITS-1:0]        word_t;
    typedef logic signed [`PPU_LANE_BITS-1:0] lane_t;  // one psum accumulation
    typedef logic [7:0]                       byte_t;  // quantized result

    // byte enable pattern, other codes behave as none
    typedef enum logic [3:0] {
        LANE_NONE  = 4'b0000,
        LANE_LOWER = 4'b0011,
        LANE_UPPER = 4'b1100,
        LANE_BOTH  = 4'b1111
    } lane_sel_t;

endpackage

/* ppu_ctrl_pkg.sv */
/*
 * PPU controller types
 * tile sequencing state, opcodes and command field widths
 */
package ppu_ctrl_pkg;

    `include "ppu_defines.svh"

    typedef logic [`PPU_ADDR_BITS-1:0] addr_t;  // bank word address
    typedef logic [`PPU_LEN_BITS-1:0]  len_t;   // tile length / item count
    typedef logic [4:0]                shift_t; // requant right shift

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,    // one psum read per cycle
        ST_DRAIN    // waiting on last writes
    } tile_state_t;

    typedef enum logic [1:0] {
        OP_BYPASS       = 2'd0,  // raw copy
        OP_REQUANT      = 2'd1,
        OP_REQUANT_RELU = 2'd2
    } ppu_op_t;

endpackage

/* ppu_defines.svh */
/*
 * PPU writeback stage sizing
 * word and lane widths, bank geometry, requant constants
 */
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// packed psum word, two signed lanes
`define PPU_DATA_BITS   32
`define PPU_LANE_BITS   16

// bank geometry, both banks share it
`define PPU_DEPTH       64
`define PPU_ADDR_BITS   6
`define PPU_LEN_BITS    7    // lengths 1..64

// int8 requant constants
`define PPU_ZERO_POINT  128
`define PPU_QMAX        255

`endif
